// ==== Makefile ====
# Verilator build and run of the OTP save/restore testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_emem
FILELIST  := compile.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
verilog/emem_pkg.sv
verilog/emem_program.sv
verilog/emem_array.sv
verilog/emem_restore.sv
verilog/emem_ctrl.sv
dv/tb_clkgen.sv
dv/emem_monitor.sv
dv/tb_emem.sv

// ==== dv/emem_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench checker
// Reference model of the OTP banks and the saved-bank count, compares
// replayed bytes, done strobes, busy levels and bank status, counts checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module emem_monitor #(
  parameter int NUM_BANKS = emem_pkg::num_banks,
  localparam int CNT_W = $clog2(NUM_BANKS + 1)
) (
  input  logic                                          wr_clk,
  input  logic                                          reset,
  input  logic                                          rd_start,
  input  logic                                          wr_start,
  input  emem_pkg::em_byte_t [emem_pkg::data_bytes-1:0] em_data,
  input  logic                                          rd_busy,
  input  logic                                          wr_busy,
  input  logic                                          rd_done,
  input  logic                                          wr_done,
  input  logic                                          init_load,
  input  emem_pkg::byte_idx_t                           init_index,
  input  emem_pkg::em_byte_t                            init_data,
  input  logic [CNT_W-1:0]                              em_bank,
  input  logic                                          em_full,
  output int                                            pass_count,
  output int                                            fail_count
);

  localparam int BB = emem_pkg::block_bytes;

  // Model cells keep their contents through reset
  emem_pkg::em_byte_t model_mem [];
  emem_pkg::em_byte_t snap_q [$];
  int                 model_count;
  int                 scan_count;
  int                 load_idx;
  bit                 save_pend;
  bit                 restore_pend;
  bit                 status_due;
  bit                 seq_idle;

  initial
  begin
    model_mem = new[NUM_BANKS * BB];
    foreach (model_mem[a])
      model_mem[a] = emem_pkg::erased_byte;
    pass_count   = 0;
    fail_count   = 0;
    model_count  = 0;
    scan_count   = 0;
    load_idx     = 0;
    save_pend    = 1'b0;
    restore_pend = 1'b0;
    status_due   = 1'b0;
    seq_idle     = 1'b1;
  end

  function automatic void compare_value(input string what, input int got, input int expected);
    if (got == expected)
      pass_count++;
    else
    begin
      fail_count++;
      $display("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
    end
  endfunction

  function automatic void report_error(input string what);
    fail_count++;
    $display("error at %0d ns: %s", $time, what);
  endfunction

  // Saved banks form a run from bank 0 up to the first unmarked bank
  function automatic int count_saved_banks();
    int n;
    n = 0;
    while (n < NUM_BANKS && model_mem[n * BB + BB - 1] == emem_pkg::saved_byte)
      n++;
    return n;
  endfunction

  // Byte i of the snapshot lands at offset i
  function automatic void capture_snapshot();
    emem_pkg::em_byte_t [emem_pkg::data_bytes-1:0] snap;
    snap = em_data;
    snap_q.delete();
    for (int i = 0; i < emem_pkg::data_bytes; i++)
    begin
      snap_q.push_back(snap[0]);
      snap = {emem_pkg::em_byte_t'(0), snap[emem_pkg::data_bytes-1:1]};
    end
  endfunction

  // Programming only clears bits
  function automatic void program_bank(input int bank);
    for (int i = 0; i < emem_pkg::data_bytes; i++)
      model_mem[bank * BB + i] = model_mem[bank * BB + i] & snap_q[i];
    model_mem[bank * BB + BB - 1] = model_mem[bank * BB + BB - 1] & emem_pkg::saved_byte;
  endfunction

  function automatic void check_load();
    if (!restore_pend || scan_count == 0 || load_idx >= emem_pkg::data_bytes)
      report_error("init_load strobe outside a replay");
    else
    begin
      compare_value("init_index", int'(init_index), load_idx);
      compare_value("init_data", int'(init_data),
                    int'(model_mem[(scan_count - 1) * BB + load_idx]));
      load_idx++;
    end
  endfunction

  function automatic void finish_restore();
    if (!restore_pend)
      report_error("rd_done arrived without an accepted restore");
    else
    begin
      compare_value("init_load count", load_idx, (scan_count > 0) ? emem_pkg::data_bytes : 0);
      model_count  = scan_count;
      restore_pend = 1'b0;
      status_due   = 1'b1;
    end
  endfunction

  function automatic void finish_save();
    if (!save_pend)
      report_error("wr_done arrived without an accepted save");
    else
    begin
      // A full array completes the save without a write
      if (model_count < NUM_BANKS)
      begin
        program_bank(model_count);
        model_count++;
      end
      save_pend  = 1'b0;
      status_due = 1'b1;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Sampling at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge wr_clk)
  begin
    if (!reset)
    begin
      model_count  = 0;
      save_pend    = 1'b0;
      restore_pend = 1'b0;
      status_due   = 1'b1;
    end
    else
    begin
      // Sequencers stay busy through their done cycle
      seq_idle = !restore_pend && !save_pend;
      compare_value("rd_busy", int'(rd_busy), int'(restore_pend));
      compare_value("wr_busy", int'(wr_busy), int'(save_pend));
      // Bank status once both sequencers are idle again
      if (status_due && seq_idle)
      begin
        compare_value("em_bank", int'(em_bank), model_count);
        compare_value("em_full", int'(em_full), int'(model_count == NUM_BANKS));
        status_due = 1'b0;
      end
      if (init_load)
        check_load();
      if (rd_done)
        finish_restore();
      if (wr_done)
        finish_save();
      // Read wins a same-cycle tie
      if (seq_idle && rd_start)
      begin
        restore_pend = 1'b1;
        scan_count   = count_saved_banks();
        load_idx     = 0;
      end
      else if (seq_idle && wr_start)
      begin
        save_pend = 1'b1;
        capture_snapshot();
      end
    end
  end

endmodule

// ==== dv/tb_clkgen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
// Free-running clock, power-on reset and a request input for extra resets
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  input  logic reset_req,
  output logic wr_clk,
  output logic reset
);

  logic por_done;

  initial
  begin
    wr_clk = 1'b0;
    forever
      #(PERIOD_NS / 2) wr_clk = ~wr_clk;
  end

  // Power-on reset released on a falling edge
  initial
  begin
    por_done = 1'b0;
    repeat (RESET_CYCLES)
      @(negedge wr_clk);
    por_done = 1'b1;
  end

  // Active low, also pulled by the testbench for a mid-run reset
  assign reset = por_done && !reset_req;

endmodule

// ==== dv/tb_emem.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench top for the OTP save/restore controller
// Clock generator, DUT and checker, random save and restore sequences,
// cycle limit and the final verdict
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_emem;

  localparam int NUM_BANKS = emem_pkg::num_banks;
  localparam int CNT_W     = $clog2(NUM_BANKS + 1);

  // Six tests, budgeted as eight for margin
  localparam int BUDGET_TESTS = 8;
  localparam int TEST_CYCLES  = 200;
  localparam int MAX_CYCLES   = BUDGET_TESTS * TEST_CYCLES;

  logic                                          wr_clk;
  logic                                          reset;
  logic                                          reset_req;
  logic                                          rd_start;
  logic                                          wr_start;
  emem_pkg::em_byte_t [emem_pkg::data_bytes-1:0] em_data;
  logic                                          rd_busy;
  logic                                          wr_busy;
  logic                                          rd_done;
  logic                                          wr_done;
  logic                                          init_load;
  emem_pkg::byte_idx_t                           init_index;
  emem_pkg::em_byte_t                            init_data;
  logic [CNT_W-1:0]                              em_bank;
  logic                                          em_full;
  int                                            pass_count;
  int                                            fail_count;

  integer seed;
  int     tb_errors   = 0;
  int     err_mark    = 0;
  int     cycle_count = 0;

  tb_clkgen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (10)
  ) clkgen (
    .reset_req    (reset_req),
    .wr_clk       (wr_clk),
    .reset        (reset)
  );

  emem_ctrl #(
    .NUM_BANKS  (NUM_BANKS)
  ) dut (
    .wr_clk     (wr_clk),
    .reset      (reset),
    .rd_start   (rd_start),
    .wr_start   (wr_start),
    .em_data    (em_data),
    .rd_busy    (rd_busy),
    .wr_busy    (wr_busy),
    .rd_done    (rd_done),
    .wr_done    (wr_done),
    .init_load  (init_load),
    .init_index (init_index),
    .init_data  (init_data),
    .em_bank    (em_bank),
    .em_full    (em_full)
  );

  emem_monitor #(
    .NUM_BANKS  (NUM_BANKS)
  ) monitor (
    .wr_clk     (wr_clk),
    .reset      (reset),
    .rd_start   (rd_start),
    .wr_start   (wr_start),
    .em_data    (em_data),
    .rd_busy    (rd_busy),
    .wr_busy    (wr_busy),
    .rd_done    (rd_done),
    .wr_done    (wr_done),
    .init_load  (init_load),
    .init_index (init_index),
    .init_data  (init_data),
    .em_bank    (em_bank),
    .em_full    (em_full),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all driving on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_random_snapshot();
    for (int i = 0; i < emem_pkg::data_bytes; i++)
      em_data = {em_data[emem_pkg::data_bytes-2:0], emem_pkg::em_byte_t'($random(seed))};
  endtask

  // Start requests last one cycle
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge wr_clk);
      rd_start = 1'b0;
      wr_start = 1'b0;
    end
  endtask

  task automatic request_start(input bit is_read);
    @(negedge wr_clk);
    if (is_read)
      rd_start = 1'b1;
    else
    begin
      load_random_snapshot();
      wr_start = 1'b1;
    end
  endtask

  task automatic await_done(input bit is_read);
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < TEST_CYCLES)
    begin
      @(negedge wr_clk);
      rd_start = 1'b0;
      wr_start = 1'b0;
      seen     = is_read ? rd_done : wr_done;
      waited++;
    end
    if (!seen)
    begin
      $display("error: %s did not arrive within %0d cycles",
               is_read ? "rd_done" : "wr_done", TEST_CYCLES);
      tb_errors++;
    end
  endtask

  task automatic save_block();
    request_start(1'b0);
    await_done(1'b0);
  endtask

  task automatic restore_block();
    request_start(1'b1);
    await_done(1'b1);
  endtask

  task automatic apply_reset();
    @(negedge wr_clk);
    reset_req = 1'b1;
    idle_cycles(3);
    reset_req = 1'b0;
    idle_cycles(2);
  endtask

  task automatic report_test(input int num, input string name);
    int errs;
    // Let the checker finish its status compare
    idle_cycles(2);
    errs     = fail_count + tb_errors - err_mark;
    err_mark = fail_count + tb_errors;
    if (errs == 0)
      $display("test %0d, %s: ok", num, name);
    else
      $display("test %0d, %s: %0d errors", num, name, errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed      = 32'h3f9e_762c;
    reset_req = 1'b0;
    rd_start  = 1'b0;
    wr_start  = 1'b0;
    em_data   = '0;
    wait (reset === 1'b1);
    idle_cycles(2);

    restore_block();
    report_test(1, "restore of erased array");

    save_block();
    restore_block();
    report_test(2, "save then restore");

    save_block();
    save_block();
    restore_block();
    report_test(3, "newest of several saves");

    // Fills the last bank, then one save too many
    save_block();
    save_block();
    restore_block();
    report_test(4, "save into full array");

    apply_reset();
    restore_block();
    report_test(5, "bank count found after reset");

    request_start(1'b1);
    idle_cycles(4);
    request_start(1'b0);
    await_done(1'b1);
    idle_cycles(40);
    report_test(6, "save request during restore");

    $display("checks passed %0d, failed %0d, testbench errors %0d",
             pass_count, fail_count, tb_errors);
    if (fail_count == 0 && tb_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // Run limit
  always @(posedge wr_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("test failed");
      $finish;
    end
  end

endmodule

// ==== verilog/emem_array.sv ====
////////////////////////////////////////////////////////////////////////////
// One-time-programmable byte array model
// Single program port that can only clear bits, registered read port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module emem_array #(
  parameter int NUM_BANKS = emem_pkg::num_banks
) (
  input  logic               wr_clk,
  input  logic               prog_we,
  input  emem_pkg::addr_t    prog_addr,
  input  emem_pkg::em_byte_t prog_data,
  input  emem_pkg::addr_t    rd_addr,
  output emem_pkg::em_byte_t rd_data
);

  localparam int DEPTH = NUM_BANKS * emem_pkg::block_bytes;

  // Cells start erased and keep their contents through reset
  emem_pkg::em_byte_t cells [DEPTH] = '{default: emem_pkg::erased_byte};

  ////////////////////////////////////////////////////////////////////////////
  // Program port
  ////////////////////////////////////////////////////////////////////////////

  // A programmed zero never returns to one
  always_ff @(posedge wr_clk)
  begin
    if (prog_we)
      cells[prog_addr] <= cells[prog_addr] & prog_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Data valid one cycle after the address
  always_ff @(posedge wr_clk)
  begin
    rd_data <= cells[rd_addr];
  end

endmodule

// ==== verilog/emem_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Save/restore controller top level
// Save sequencer, OTP byte array and restore sequencer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module emem_ctrl #(
  parameter int NUM_BANKS = emem_pkg::num_banks,
  localparam int CNT_W = $clog2(NUM_BANKS + 1)
) (
  input  logic                                          wr_clk,
  input  logic                                          reset,
  input  logic                                          rd_start,
  input  logic                                          wr_start,
  input  emem_pkg::em_byte_t [emem_pkg::data_bytes-1:0] em_data,
  output logic                                          rd_busy,
  output logic                                          wr_busy,
  output logic                                          rd_done,
  output logic                                          wr_done,
  output logic                                          init_load,
  output emem_pkg::byte_idx_t                           init_index,
  output emem_pkg::em_byte_t                            init_data,
  output logic [CNT_W-1:0]                              em_bank,
  output logic                                          em_full
);

  // Program port
  logic               prog_we;
  emem_pkg::addr_t    prog_addr;
  emem_pkg::em_byte_t prog_data;

  // Read port
  emem_pkg::addr_t    rd_addr;
  emem_pkg::em_byte_t rd_data;

  // Between the sequencers
  logic [CNT_W-1:0]   bank_count;
  logic               save_commit;

  emem_program #(
    .NUM_BANKS   (NUM_BANKS)
  ) u_program (
    .wr_clk      (wr_clk),
    .reset       (reset),
    .wr_start    (wr_start),
    .rd_start    (rd_start),
    .em_data     (em_data),
    .rd_busy     (rd_busy),
    .bank_count  (bank_count),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .save_commit (save_commit),
    .wr_busy     (wr_busy),
    .wr_done     (wr_done)
  );

  emem_array #(
    .NUM_BANKS   (NUM_BANKS)
  ) u_array (
    .wr_clk      (wr_clk),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  emem_restore #(
    .NUM_BANKS   (NUM_BANKS)
  ) u_restore (
    .wr_clk      (wr_clk),
    .reset       (reset),
    .rd_start    (rd_start),
    .wr_busy     (wr_busy),
    .save_commit (save_commit),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .bank_count  (bank_count),
    .rd_busy     (rd_busy),
    .rd_done     (rd_done),
    .init_load   (init_load),
    .init_index  (init_index),
    .init_data   (init_data),
    .em_bank     (em_bank),
    .em_full     (em_full)
  );

endmodule

// ==== verilog/emem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the OTP save/restore controller
// Bank geometry, marker and erased cell values, byte and address types
////////////////////////////////////////////////////////////////////////////

package emem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // One memory cell
  typedef logic [7:0] em_byte_t;

  // Offset of a byte inside one bank
  typedef logic [4:0] byte_idx_t;

  // Bank number on top, byte offset below
  typedef logic [6:0] addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  // Default number of banks in the array
  localparam int num_banks = 4;

  // Bytes per bank including the marker
  localparam int block_bytes = 32;

  // Payload bytes per bank, the marker takes the last slot
  localparam int data_bytes = block_bytes - 1;

  ////////////////////////////////////////////////////////////////////////////
  // Cell values
  ////////////////////////////////////////////////////////////////////////////

  // Marker of a bank whose block was programmed to the end
  localparam em_byte_t saved_byte = 8'h00;

  // Unprogrammed cell, bits can only be cleared from here
  localparam em_byte_t erased_byte = 8'hff;

endpackage

// ==== verilog/emem_program.sv ====
////////////////////////////////////////////////////////////////////////////
// Save sequencer
// Latches the configuration snapshot and programs it into the next
// free bank, one byte per cycle, with the saved marker written last
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module emem_program #(
  parameter int NUM_BANKS = emem_pkg::num_banks,
  localparam int CNT_W = $clog2(NUM_BANKS + 1)
) (
  input  logic                                          wr_clk,
  input  logic                                          reset,
  input  logic                                          wr_start,
  input  logic                                          rd_start,
  input  emem_pkg::em_byte_t [emem_pkg::data_bytes-1:0] em_data,
  input  logic                                          rd_busy,
  input  logic [CNT_W-1:0]                              bank_count,
  output logic                                          prog_we,
  output emem_pkg::addr_t                               prog_addr,
  output emem_pkg::em_byte_t                            prog_data,
  output logic                                          save_commit,
  output logic                                          wr_busy,
  output logic                                          wr_done
);

  // Bank field of the array address
  localparam int BANK_W = $bits(emem_pkg::addr_t) - $bits(emem_pkg::byte_idx_t);
  localparam emem_pkg::byte_idx_t MARKER_OFF =
    emem_pkg::byte_idx_t'(emem_pkg::block_bytes - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_commit,
    st_skip
  } state_t;

  state_t                                        state;
  logic                                          wr_accept;
  logic                                          bank_full;
  logic [BANK_W-1:0]                             wr_bank;
  emem_pkg::byte_idx_t                           wr_off;
  emem_pkg::em_byte_t [emem_pkg::data_bytes-1:0] snap;

  // Read side wins a same-cycle tie
  assign wr_accept = wr_start && !rd_start && !rd_busy && (state == st_idle);
  assign bank_full = (bank_count == CNT_W'(NUM_BANKS));

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk or negedge reset)
  begin
    if (!reset)
    begin
      state   <= st_idle;
      wr_bank <= '0;
      wr_off  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (wr_accept)
          begin
            wr_bank <= bank_count[BANK_W-1:0];
            wr_off  <= '0;
            // No room left, report done without touching the array
            state   <= bank_full ? st_skip : st_write;
          end
        end
        st_write:
        begin
          if (wr_off == MARKER_OFF)
            state <= st_commit;
          else
            wr_off <= wr_off + emem_pkg::byte_idx_t'(1);
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Snapshot taken at acceptance
  always_ff @(posedge wr_clk)
  begin
    if (wr_accept)
      snap <= em_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Array write port and status
  ////////////////////////////////////////////////////////////////////////////

  assign prog_we   = (state == st_write);
  assign prog_addr = {wr_bank, wr_off};

  // Marker goes in the last slot so a cut-short save never counts
  assign prog_data = (wr_off == MARKER_OFF) ? emem_pkg::saved_byte : snap[wr_off];

  assign save_commit = (state == st_commit);
  assign wr_done     = (state == st_commit) || (state == st_skip);
  assign wr_busy     = (state != st_idle);

endmodule

// ==== verilog/emem_restore.sv ====
////////////////////////////////////////////////////////////////////////////
// Restore sequencer
// Scans bank markers to find how many blocks were saved, keeps the
// bank count, and replays the newest block as a byte stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module emem_restore #(
  parameter int NUM_BANKS = emem_pkg::num_banks,
  localparam int CNT_W = $clog2(NUM_BANKS + 1)
) (
  input  logic                wr_clk,
  input  logic                reset,
  input  logic                rd_start,
  input  logic                wr_busy,
  input  logic                save_commit,
  input  emem_pkg::em_byte_t  rd_data,
  output emem_pkg::addr_t     rd_addr,
  output logic [CNT_W-1:0]    bank_count,
  output logic                rd_busy,
  output logic                rd_done,
  output logic                init_load,
  output emem_pkg::byte_idx_t init_index,
  output emem_pkg::em_byte_t  init_data,
  output logic [CNT_W-1:0]    em_bank,
  output logic                em_full
);

  localparam int BANK_W = $bits(emem_pkg::addr_t) - $bits(emem_pkg::byte_idx_t);
  localparam emem_pkg::byte_idx_t MARKER_OFF =
    emem_pkg::byte_idx_t'(emem_pkg::block_bytes - 1);
  localparam emem_pkg::byte_idx_t LAST_OFF =
    emem_pkg::byte_idx_t'(emem_pkg::data_bytes - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_scan_rd,
    st_scan_chk,
    st_replay,
    st_drain,
    st_done
  } state_t;

  state_t              state;
  logic                rd_accept;
  logic                marker_ok;
  logic                scan_end;
  logic [CNT_W-1:0]    scan_cnt;
  logic [CNT_W-1:0]    scan_next;
  logic [CNT_W-1:0]    found;
  logic [CNT_W-1:0]    found_last;
  logic [BANK_W-1:0]   rep_bank;
  emem_pkg::byte_idx_t rep_off;
  logic                pipe_vld;
  emem_pkg::byte_idx_t pipe_idx;

  assign rd_accept = rd_start && !wr_busy && (state == st_idle);

  // Marker check on the byte returned for bank scan_cnt
  assign marker_ok  = (rd_data == emem_pkg::saved_byte);
  assign scan_next  = scan_cnt + CNT_W'(1);
  assign scan_end   = !marker_ok || (scan_next == CNT_W'(NUM_BANKS));
  assign found      = marker_ok ? scan_next : scan_cnt;
  assign found_last = found - CNT_W'(1);

  ////////////////////////////////////////////////////////////////////////////
  // Scan and replay FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk or negedge reset)
  begin
    if (!reset)
    begin
      state    <= st_idle;
      scan_cnt <= '0;
      rep_bank <= '0;
      rep_off  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (rd_accept)
          begin
            scan_cnt <= '0;
            state    <= st_scan_rd;
          end
        end
        // Marker address out, data back next cycle
        st_scan_rd:
          state <= st_scan_chk;
        st_scan_chk:
        begin
          if (!scan_end)
          begin
            scan_cnt <= scan_next;
            state    <= st_scan_rd;
          end
          else if (found == '0)
            state <= st_done;
          else
          begin
            rep_bank <= found_last[BANK_W-1:0];
            rep_off  <= '0;
            state    <= st_replay;
          end
        end
        st_replay:
        begin
          if (rep_off == LAST_OFF)
            state <= st_drain;
          else
            rep_off <= rep_off + emem_pkg::byte_idx_t'(1);
        end
        // Wait for the last read to leave the pipeline
        st_drain:
        begin
          if (!pipe_vld)
            state <= st_done;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk or negedge reset)
  begin
    if (!reset)
      bank_count <= '0;
    else if ((state == st_scan_chk) && scan_end)
      bank_count <= found;
    else if (save_commit)
      bank_count <= bank_count + CNT_W'(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Replay pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Valid bits follow the read address by one and two cycles
  always_ff @(posedge wr_clk or negedge reset)
  begin
    if (!reset)
    begin
      pipe_vld  <= 1'b0;
      init_load <= 1'b0;
    end
    else
    begin
      pipe_vld  <= (state == st_replay);
      init_load <= pipe_vld;
    end
  end

  always_ff @(posedge wr_clk)
  begin
    pipe_idx   <= rep_off;
    init_index <= pipe_idx;
    init_data  <= rd_data;
  end

  // New address every cycle, marker slot outside replay
  assign rd_addr = (state == st_replay) ? {rep_bank, rep_off} :
                                          {scan_cnt[BANK_W-1:0], MARKER_OFF};

  assign rd_busy = (state != st_idle);
  assign rd_done = (state == st_done);
  assign em_bank = bank_count;
  assign em_full = (bank_count == CNT_W'(NUM_BANKS));

endmodule
